// ==== Makefile ====
TOP = mipsSystemTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mipsSystem.f -o simTop

run: build
	./obj_dir/simTop

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f mipsSystem.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== mipsSystem.f ====
source/mipsPkg.sv
source/mipsControl.sv
source/mipsRegFile.sv
source/mipsExecute.sv
source/mipsCore.sv
source/mipsHostMemory.sv
source/mipsSystem.sv
verification/clockGen.sv
verification/mipsSystemTb.sv

// ==== source/mipsControl.sv ====
`timescale 1ns/1ps
module mipsControl import mipsPkg::*; (
	input  instrWord   instr,
	output ctrlSignals ctrl,
	output logic       undefined
);

	logic [5:0] op;
	logic [5:0] func;
	logic       isAdd;
	logic       isSub;
	logic       isOri;
	logic       isLw;
	logic       isSw;
	logic       isBeq;
	logic       isLui;
	logic       isJ;
	logic       isJal;
	logic       isJr;
	logic [9:0] hits; // One bit per recognized instruction

	assign op   = instr.rType.op;
	assign func = instr.rType.func; // Only meaningful for R-type

	//////////////////////////////////////////////////////////////////////
	// Instruction recognition
	assign isAdd = (op == opAdd) && (func == funcAdd);
	assign isSub = (op == opSub) && (func == funcSub);
	assign isJr  = (op == opSpecial) && (func == funcJr);
	assign isOri = op == opOri;
	assign isLw  = op == opLw;
	assign isSw  = op == opSw;
	assign isBeq = op == opBeq;
	assign isLui = op == opLui;
	assign isJ   = op == opJ;
	assign isJal = op == opJal;

	assign hits      = {isAdd, isSub, isOri, isLw, isSw, isBeq, isLui, isJ, isJal, isJr};
	assign undefined = ~|hits; // Anything else halts the core

	// Control word
	assign ctrl.regDst   = isJal ? dstRa : (isAdd || isSub) ? dstRd : dstRt;
	assign ctrl.regWrite = isAdd | isSub | isOri | isLw | isLui | isJal;
	assign ctrl.extSign  = isLw | isSw | isBeq; // ori zero-extends
	assign ctrl.aluSrc   = isOri | isLw | isSw | isLui;
	assign ctrl.aluCtrl  = isSub ? aluSub : isOri ? aluOr : isLui ? aluLui : aluAdd;
	assign ctrl.memWrite = isSw;
	assign ctrl.memToReg = isJal ? wbPc4 : isLw ? wbMem : wbAlu;
	assign ctrl.npcSel   = isBeq ? npcBeq :
	                       (isJ || isJal) ? npcJump :
	                       isJr ? npcJr : npcPc4;

	// Opcode and function patterns must never overlap
	always_comb begin
		if (!$isunknown(hits)) begin
			assert ($onehot0(hits))
				else $error("mipsControl: overlapping decode %b", hits);
		end
	end

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
module mipsCore import mipsPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  instrWord    imemData,
	output logic [7:0]  imemAddr,
	output logic [7:0]  dmemAddr,
	output logic [31:0] dmemWriteData,
	output logic        dmemWriteEn,
	input  logic [31:0] dmemReadData,
	input  logic [4:0]  regHostAddr,
	output logic [31:0] regHostData,
	output logic        busy,
	output logic        halted,
	output logic [15:0] haltPc
);

	logic [1:0]  state;
	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] nextPc;
	logic [31:0] branchOffset;
	instrWord    instrReg;  // Held from fetch to writeback
	logic [31:0] aluReg;    // Latched in execute
	ctrlSignals  ctrl;
	logic        undefined;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] aluResult;
	logic        equal;
	logic [4:0]  writeAddr;
	logic [31:0] writeData;
	logic        inWriteback;

	mipsControl u_mipsControl (
		.instr     (instrReg),
		.ctrl      (ctrl),
		.undefined (undefined)
	);

	mipsRegFile u_mipsRegFile (
		.clk       (clk),
		.reset     (reset),
		.rsAddr    (instrReg.rType.rs),
		.rtAddr    (instrReg.rType.rt),
		.writeAddr (writeAddr),
		.hostAddr  (regHostAddr),
		.writeEn   (inWriteback && ctrl.regWrite),
		.writeData (writeData),
		.rsData    (rsData),
		.rtData    (rtData),
		.hostData  (regHostData)
	);

	mipsExecute u_mipsExecute (
		.ctrl      (ctrl),
		.instr     (instrReg),
		.rsData    (rsData),
		.rtData    (rtData),
		.aluResult (aluResult),
		.equal     (equal)
	);

	//////////////////////////////////////////////////////////////////////
	// FSM, one instruction per four states
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= stFetch;
			pc     <= '0;
			busy   <= 1'b0;
			halted <= 1'b0;
			haltPc <= '0;
		end else if (start) begin // Host guarantees not busy
			state  <= stFetch;
			pc     <= '0;
			busy   <= 1'b1;
			halted <= 1'b0;
		end else if (busy) begin
			case (state)
				stFetch: state <= stDecode;
				stDecode: begin
					if (undefined) begin // Stop here, PC of bad word kept
						busy   <= 1'b0;
						halted <= 1'b1;
						haltPc <= pc[15:0];
						state  <= stFetch;
					end else begin
						state <= stExecute;
					end
				end
				stExecute: state <= stWriteback;
				default: begin
					pc    <= nextPc;
					state <= stFetch;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (busy && state == stFetch) instrReg <= imemData;
		if (busy && state == stExecute) aluReg <= aluResult;
	end

	assign inWriteback = busy && state == stWriteback;

	// Next PC
	assign pcPlus4      = pc + 32'd4;
	assign branchOffset = {{14{instrReg.iType.imm[15]}}, instrReg.iType.imm, 2'b00};
	always_comb begin
		case (ctrl.npcSel)
			npcBeq:  nextPc = equal ? pcPlus4 + branchOffset : pcPlus4;
			npcJump: nextPc = {pcPlus4[31:28], instrReg.jType.target, 2'b00};
			npcJr:   nextPc = rsData;
			default: nextPc = pcPlus4;
		endcase
	end

	// Writeback select
	assign writeAddr = (ctrl.regDst == dstRa) ? 5'd31 :
	                   (ctrl.regDst == dstRd) ? instrReg.rType.rd : instrReg.rType.rt;
	assign writeData = (ctrl.memToReg == wbMem) ? dmemReadData :
	                   (ctrl.memToReg == wbPc4) ? pcPlus4 : aluReg;

	assign imemAddr      = pc[9:2];     // Word index
	assign dmemAddr      = aluReg[9:2];
	assign dmemWriteData = rtData;
	assign dmemWriteEn   = inWriteback && ctrl.memWrite;

	// Stores only follow a completed execute
	assert property (@(posedge clk) disable iff (reset)
		dmemWriteEn |-> $past(busy && state == stExecute));

endmodule

// ==== source/mipsExecute.sv ====
`timescale 1ns/1ps
module mipsExecute import mipsPkg::*; (
	input  ctrlSignals  ctrl,
	input  instrWord    instr,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic [31:0] aluResult,
	output logic        equal
);

	logic [15:0] imm;
	logic [31:0] immExt;
	logic [31:0] operandB;

	assign imm = instr.iType.imm;

	// Sign for lw, sw, beq; zero for ori
	assign immExt = ctrl.extSign ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	assign operandB = ctrl.aluSrc ? immExt : rtData; // Immediate or rt

	//////////////////////////////////////////////////////////////////////
	// ALU
	always_comb begin
		case (ctrl.aluCtrl)
			aluAdd:  aluResult = rsData + operandB; // Also lw/sw address
			aluSub:  aluResult = rsData - operandB;
			aluOr:   aluResult = rsData | operandB;
			aluLui:  aluResult = {imm, 16'h0000}; // rs ignored
			default: aluResult = '0;
		endcase
	end

	// beq compare, independent of ALU op
	assign equal = rsData == rtData;

endmodule

// ==== source/mipsHostMemory.sv ====
`timescale 1ns/1ps
module mipsHostMemory import mipsPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  apbReq       apbIn,
	output apbRsp       apbOut,
	input  logic [7:0]  imemAddr,
	output instrWord    imemData,
	input  logic [7:0]  dmemAddr,
	input  logic [31:0] dmemWriteData,
	input  logic        dmemWriteEn,
	output logic [31:0] dmemReadData,
	output logic [4:0]  regHostAddr,
	input  logic [31:0] regHostData,
	input  logic        busy,
	input  logic        halted,
	input  logic [15:0] haltPc,
	output logic        start
);

	logic [31:0] imem [imemWords];
	logic [31:0] dmem [dmemWords];
	logic        setup;
	logic        access;
	logic [7:0]  wordAddr;
	logic        imemHit;
	logic        dmemHit;
	logic        regHit;
	logic        ctrlHit;
	logic        statusHit;
	logic        slvErr;
	logic        writeOk;
	logic [31:0] readMux;
	logic [31:0] readReg; // prdata, captured in setup

	assign setup    = apbIn.psel && !apbIn.penable;
	assign access   = apbIn.psel && apbIn.penable;
	assign wordAddr = apbIn.paddr[9:2];

	//////////////////////////////////////////////////////////////////////
	// Address decode
	assign imemHit   = apbIn.paddr[11:10] == imemBase[11:10];
	assign dmemHit   = apbIn.paddr[11:10] == dmemBase[11:10];
	assign regHit    = apbIn.paddr[11:10] == regBase[11:10] && wordAddr < regWords;
	assign ctrlHit   = apbIn.paddr == ctrlAddr;
	assign statusHit = apbIn.paddr == statusAddr;

	// Unmapped, or imem/regs write while running
	assign slvErr  = !(imemHit || dmemHit || regHit || ctrlHit || statusHit) ||
	                 (apbIn.pwrite && busy && (imemHit || regHit));
	assign writeOk = access && apbIn.pwrite && !slvErr;
	assign start   = writeOk && ctrlHit && apbIn.pwdata[0] && !busy;

	assign regHostAddr = apbIn.paddr[6:2];

	always_comb begin
		if (imemHit) readMux = imem[wordAddr];
		else if (dmemHit) readMux = dmem[wordAddr];
		else if (regHit) readMux = regHostData;
		else if (statusHit) readMux = {haltPc, 14'h0000, halted, busy};
		else readMux = '0; // ctrl reads as zero
	end

	always_ff @(posedge clk) begin
		if (reset) readReg <= '0;
		else if (setup) readReg <= readMux;
	end

	// Memories
	always_ff @(posedge clk) begin
		if (writeOk && imemHit) imem[wordAddr] <= apbIn.pwdata;
	end

	always_ff @(posedge clk) begin
		if (dmemWriteEn) dmem[dmemAddr] <= dmemWriteData;
		if (writeOk && dmemHit) dmem[wordAddr] <= apbIn.pwdata; // Host last
	end

	assign imemData     = imem[imemAddr];
	assign dmemReadData = dmem[dmemAddr];

	assign apbOut.prdata  = readReg;
	assign apbOut.pready  = 1'b1; // No wait states
	assign apbOut.pslverr = access && slvErr;

	// Access phase only after a setup phase
	assert property (@(posedge clk) disable iff (reset)
		apbIn.penable |-> apbIn.psel && $past(apbIn.psel && !apbIn.penable));

endmodule

// ==== source/mipsPkg.sv ====
package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Opcodes and function codes, MIPS encoding
	localparam logic [5:0] opSpecial = 6'h00; // R-type group
	localparam logic [5:0] opAdd     = opSpecial;
	localparam logic [5:0] opSub     = opSpecial;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	localparam logic [5:0] funcAdd = 6'h20;
	localparam logic [5:0] funcSub = 6'h22;
	localparam logic [5:0] funcJr  = 6'h08;

	// ALU operations
	localparam logic [2:0] aluAdd = 3'b000;
	localparam logic [2:0] aluSub = 3'b001;
	localparam logic [2:0] aluOr  = 3'b010;
	localparam logic [2:0] aluLui = 3'b101; // Imm to upper half

	// Next-PC select
	localparam logic [1:0] npcPc4  = 2'b00;
	localparam logic [1:0] npcJump = 2'b01; // j and jal
	localparam logic [1:0] npcBeq  = 2'b10;
	localparam logic [1:0] npcJr   = 2'b11;

	// Destination register and writeback source
	localparam logic [1:0] dstRt = 2'b00;
	localparam logic [1:0] dstRd = 2'b01;
	localparam logic [1:0] dstRa = 2'b10; // Register 31
	localparam logic [1:0] wbAlu = 2'b00;
	localparam logic [1:0] wbMem = 2'b01;
	localparam logic [1:0] wbPc4 = 2'b10;

	// Core FSM states
	localparam logic [1:0] stFetch     = 2'd0;
	localparam logic [1:0] stDecode    = 2'd1;
	localparam logic [1:0] stExecute   = 2'd2;
	localparam logic [1:0] stWriteback = 2'd3;

	//////////////////////////////////////////////////////////////////////
	// APB address map, byte addresses on a 12-bit paddr
	localparam logic [11:0] imemBase   = 12'h000;
	localparam logic [11:0] dmemBase   = 12'h400;
	localparam logic [11:0] regBase    = 12'h800;
	localparam logic [11:0] ctrlAddr   = 12'hC00; // Bit 0 starts the core
	localparam logic [11:0] statusAddr = 12'hC04; // haltPc, halted, busy
	localparam int imemWords = 256;
	localparam int dmemWords = 256;
	localparam int regWords  = 32;

	typedef struct packed {
		logic [1:0] regDst;
		logic       regWrite;
		logic       extSign;  // 1 sign, 0 zero
		logic       aluSrc;   // 1 selects immediate
		logic [2:0] aluCtrl;
		logic       memWrite;
		logic [1:0] memToReg;
		logic [1:0] npcSel;
	} ctrlSignals;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] func;
		} rType;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target;
		} jType;
	} instrWord;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRsp;

endpackage

// ==== source/mipsRegFile.sv ====
`timescale 1ns/1ps
module mipsRegFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic [4:0]  writeAddr,
	input  logic [4:0]  hostAddr,
	input  logic        writeEn,
	input  logic [31:0] writeData,
	output logic [31:0] rsData,
	output logic [31:0] rtData,
	output logic [31:0] hostData
);

	logic [31:0] regs [32]; // Entry 0 never written

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Combinational reads, $zero held by reset and the write guard
	assign rsData   = regs[rsAddr];
	assign rtData   = regs[rtAddr];
	assign hostData = regs[hostAddr]; // Host debug port

	// $zero stays zero after a write aimed at it
	assert property (@(posedge clk) disable iff (reset)
		(writeEn && writeAddr == 5'd0) |=> (rsAddr != 5'd0 || rsData == '0));

endmodule

// ==== source/mipsSystem.sv ====
`timescale 1ns/1ps
module mipsSystem import mipsPkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  apbReq apbIn,
	output apbRsp apbOut
);

	logic [7:0]  imemAddr;
	instrWord    imemData;
	logic [7:0]  dmemAddr;
	logic [31:0] dmemWriteData;
	logic        dmemWriteEn;
	logic [31:0] dmemReadData;
	logic [4:0]  regHostAddr;
	logic [31:0] regHostData;
	logic        busy;
	logic        halted;
	logic [15:0] haltPc;
	logic        start;

	mipsCore u_mipsCore (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.imemData      (imemData),
		.imemAddr      (imemAddr),
		.dmemAddr      (dmemAddr),
		.dmemWriteData (dmemWriteData),
		.dmemWriteEn   (dmemWriteEn),
		.dmemReadData  (dmemReadData),
		.regHostAddr   (regHostAddr),
		.regHostData   (regHostData),
		.busy          (busy),
		.halted        (halted),
		.haltPc        (haltPc)
	);

	mipsHostMemory u_mipsHostMemory (
		.clk           (clk),
		.reset         (reset),
		.apbIn         (apbIn),
		.apbOut        (apbOut),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.dmemAddr      (dmemAddr),
		.dmemWriteData (dmemWriteData),
		.dmemWriteEn   (dmemWriteEn),
		.dmemReadData  (dmemReadData),
		.regHostAddr   (regHostAddr),
		.regHostData   (regHostData),
		.busy          (busy),
		.halted        (halted),
		.haltPc        (haltPc),
		.start         (start)
	);

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps
module clockGen (
	output logic clk,
	output logic reset
);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk); // Held 16 cycles
		reset <= 1'b0;
	end

endmodule

// ==== verification/mipsSystemTb.sv ====
`timescale 1ns/1ps
module mipsSystemTb import mipsPkg::*; ();

	// Five programs under 30 instructions at 4 cycles, APB traffic ~4 cycles per access
	localparam int cycleLimit = 20000;
	localparam logic [31:0] haltWord = {6'h3f, 26'd0}; // Opcode outside the set

	logic        clk;
	logic        reset;
	apbReq       apbIn;
	apbRsp       apbOut;
	logic [31:0] progWords [$]; // Program image, word 0 first
	int          cycleCount = 0;
	int          checkFailures = 0;
	int unsigned seedValue;

	clockGen u_clockGen (
		.clk   (clk),
		.reset (reset)
	);

	mipsSystem u_mipsSystem (
		.clk    (clk),
		.reset  (reset),
		.apbIn  (apbIn),
		.apbOut (apbOut)
	);

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and run limit
	task automatic reportFailure(input string reason);
		checkFailures++;
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at first failure");
	endtask

	task automatic expectEqual(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			reportFailure($sformatf("Mismatch %s expected %h actual %h",
				testName, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			reportFailure("Timeout: the run did not finish within the cycle limit");
		end
	end

	// APB response rules
	assert property (@(posedge clk) disable iff (reset) apbOut.pready)
		else reportFailure("APB pready dropped low");
	assert property (@(posedge clk) disable iff (reset)
		apbOut.pslverr |-> apbIn.psel && apbIn.penable)
		else reportFailure("APB pslverr raised outside an access cycle");

	//////////////////////////////////////////////////////////////////////
	// Instruction encoders, MIPS field layout
	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] func);
		return {opSpecial, rs, rt, rd, 5'd0, func};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [5:0] op, input int index);
		return {op, 26'(index)}; // Target is a word index
	endfunction

	// Offset counts words from the slot after the branch
	function automatic logic [31:0] encBeq(input logic [4:0] rs, input logic [4:0] rt,
			input int from, input int to);
		return encI(opBeq, rs, rt, 16'(to - from - 1));
	endfunction

	function automatic logic [11:0] imemAt(input int index);
		return imemBase + 12'(index * 4);
	endfunction

	function automatic logic [11:0] dmemAt(input int index);
		return dmemBase + 12'(index * 4);
	endfunction

	function automatic logic [11:0] regAt(input int index);
		return regBase + 12'(index * 4);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB master, setup then access, sampled mid access cycle
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apbIn.psel    <= 1'b1;
		apbIn.penable <= 1'b0;
		apbIn.pwrite  <= write;
		apbIn.paddr   <= addr;
		apbIn.pwdata  <= wdata;
		@(posedge clk);
		apbIn.penable <= 1'b1;
		@(negedge clk);
		rdata = apbOut.prdata;
		err   = apbOut.pslverr;
		@(posedge clk); // Write commits here
		apbIn.psel    <= 1'b0;
		apbIn.penable <= 1'b0;
		apbIn.pwrite  <= 1'b0;
	endtask

	task automatic hostWrite(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apbTransfer(1'b1, addr, data, rdata, err);
		expectEqual($sformatf("pslverr on write %h", addr), 32'd0, {31'd0, err});
	endtask

	task automatic hostRead(input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apbTransfer(1'b0, addr, 32'd0, data, err);
		expectEqual($sformatf("pslverr on read %h", addr), 32'd0, {31'd0, err});
	endtask

	task automatic loadProgram();
		foreach (progWords[i]) begin
			hostWrite(imemAt(i), progWords[i]);
		end
	endtask

	task automatic startCore();
		hostWrite(ctrlAddr, 32'd1);
	endtask

	// Poll until halted and idle
	task automatic waitHalted();
		logic [31:0] status;
		status = 32'd0;
		while (!(status[1] && !status[0])) begin
			hostRead(statusAddr, status);
		end
	endtask

	task automatic runProgram();
		loadProgram();
		startCore();
		waitHalted();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	task automatic testApbAccess();
		logic [31:0] imemShadow [8];
		logic [31:0] dmemShadow [8];
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < 8; i++) begin
			imemShadow[i] = $urandom();
			dmemShadow[i] = $urandom();
			hostWrite(imemAt(200 + i), imemShadow[i]); // Clear of all programs
			hostWrite(dmemAt(100 + i), dmemShadow[i]);
		end
		for (int i = 0; i < 8; i++) begin
			hostRead(imemAt(200 + i), data);
			expectEqual($sformatf("apb imem word %0d", 200 + i), imemShadow[i], data);
			hostRead(dmemAt(100 + i), data);
			expectEqual($sformatf("apb dmem word %0d", 100 + i), dmemShadow[i], data);
		end

		// Register window stops at word 31
		apbTransfer(1'b0, regAt(32), 32'd0, data, err);
		expectEqual("apb unmapped read", 32'd1, {31'd0, err});
		apbTransfer(1'b1, 12'hC08, 32'h1234_5678, data, err);
		expectEqual("apb unmapped write", 32'd1, {31'd0, err});

		// Eight ori keep the core busy for over 30 cycles
		progWords.delete();
		for (int i = 0; i < 8; i++) begin
			progWords.push_back(encI(opOri, 5'd0, 5'd7, 16'(i)));
		end
		progWords.push_back(haltWord);
		loadProgram();
		startCore();
		apbTransfer(1'b1, imemAt(200), ~imemShadow[0], data, err);
		expectEqual("apb imem write while busy", 32'd1, {31'd0, err});
		hostRead(statusAddr, data);
		expectEqual("apb busy bit while running", 32'd1, {31'd0, data[0]});
		waitHalted();
		hostRead(imemAt(200), data);
		expectEqual("apb imem after rejected write", imemShadow[0], data);
		hostRead(regAt(7), data);
		expectEqual("apb program r7", 32'd7, data); // Last ori wins
	endtask

	task automatic testArithmetic();
		logic [15:0] aLo;
		logic [15:0] bHi;
		logic [15:0] bLo;
		logic [15:0] cHi;
		logic [31:0] expected [7];
		logic [31:0] data;
		aLo = 16'($urandom()) | 16'h8000; // Top bit set so zero extension shows
		bHi = 16'($urandom());
		bLo = 16'($urandom());
		cHi = 16'($urandom());
		progWords.delete();
		progWords.push_back(encI(opOri, 5'd0, 5'd1, aLo));
		progWords.push_back(encI(opLui, 5'd0, 5'd2, bHi));
		progWords.push_back(encI(opOri, 5'd2, 5'd2, bLo));
		progWords.push_back(encR(5'd1, 5'd2, 5'd3, funcAdd));
		progWords.push_back(encR(5'd1, 5'd2, 5'd4, funcSub));
		progWords.push_back(encI(opLui, 5'd0, 5'd5, cHi));
		progWords.push_back(encR(5'd1, 5'd2, 5'd0, funcAdd)); // Aimed at $zero
		progWords.push_back(encR(5'd2, 5'd1, 5'd6, funcSub));
		progWords.push_back(haltWord);
		runProgram();

		expected[0] = 32'd0;
		expected[1] = {16'h0000, aLo}; // ori zero-extends
		expected[2] = {bHi, bLo};
		expected[3] = expected[1] + expected[2];
		expected[4] = expected[1] - expected[2];
		expected[5] = {cHi, 16'h0000};
		expected[6] = expected[2] - expected[1];
		for (int r = 0; r < 7; r++) begin
			hostRead(regAt(r), data);
			expectEqual($sformatf("arith r%0d", r), expected[r], data);
		end
	endtask

	task automatic testMemory();
		logic [15:0] vHi;
		logic [15:0] vLo;
		logic [31:0] value;
		logic [31:0] data;
		int          storeIndex;
		vHi        = 16'($urandom());
		vLo        = 16'($urandom());
		value      = {vHi, vLo};
		storeIndex = (128 - 8) / 4; // Base 0x80, offset -8
		hostWrite(dmemAt(storeIndex), ~value); // Old word differs from the store
		progWords.delete();
		progWords.push_back(encI(opOri, 5'd0, 5'd1, 16'h0080));
		progWords.push_back(encI(opLui, 5'd0, 5'd2, vHi));
		progWords.push_back(encI(opOri, 5'd2, 5'd2, vLo));
		progWords.push_back(encI(opSw, 5'd1, 5'd2, 16'hFFF8));
		progWords.push_back(encI(opLw, 5'd1, 5'd3, 16'hFFF8));
		progWords.push_back(haltWord);
		runProgram();
		hostRead(regAt(3), data);
		expectEqual("memory lw into r3", value, data);
		hostRead(dmemAt(storeIndex), data);
		expectEqual("memory host view of stored word", value, data);
	endtask

	task automatic testControlFlow();
		int          regList [6];
		logic [31:0] expected [6];
		logic [31:0] data;
		progWords.delete();
		progWords.push_back(encI(opOri, 5'd0, 5'd1, 16'd5));      // 0
		progWords.push_back(encI(opOri, 5'd0, 5'd2, 16'd5));      // 1
		progWords.push_back(encI(opOri, 5'd0, 5'd3, 16'd7));      // 2
		progWords.push_back(encI(opOri, 5'd0, 5'd10, 16'd0));     // 3 clear markers
		progWords.push_back(encI(opOri, 5'd0, 5'd12, 16'd0));     // 4
		progWords.push_back(encBeq(5'd1, 5'd2, 5, 7));            // 5 taken
		progWords.push_back(encI(opOri, 5'd0, 5'd10, 16'h0BAD));  // 6 skipped
		progWords.push_back(encBeq(5'd1, 5'd3, 7, 9));            // 7 not taken
		progWords.push_back(encI(opOri, 5'd0, 5'd11, 16'h0011));  // 8
		progWords.push_back(encJ(opJ, 11));                       // 9
		progWords.push_back(encI(opOri, 5'd0, 5'd12, 16'h0BAD));  // 10 skipped
		progWords.push_back(encJ(opJal, 14));                     // 11 call
		progWords.push_back(encI(opOri, 5'd0, 5'd13, 16'h0013));  // 12 return point
		progWords.push_back(encJ(opJ, 16));                       // 13
		progWords.push_back(encI(opOri, 5'd0, 5'd14, 16'h0014));  // 14 subroutine
		progWords.push_back(encR(5'd31, 5'd0, 5'd0, funcJr));     // 15
		progWords.push_back(haltWord);                            // 16
		runProgram();

		regList[0] = 10;
		expected[0] = 32'd0;
		regList[1] = 11;
		expected[1] = 32'h11;
		regList[2] = 12;
		expected[2] = 32'd0;
		regList[3] = 13;
		expected[3] = 32'h13;
		regList[4] = 14;
		expected[4] = 32'h14;
		regList[5] = 31;
		expected[5] = 32'((11 + 1) * 4); // PC of jal plus 4
		for (int k = 0; k < 6; k++) begin
			hostRead(regAt(regList[k]), data);
			expectEqual($sformatf("flow r%0d", regList[k]), expected[k], data);
		end
	endtask

	task automatic testHaltStatus();
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] z;
		logic [31:0] expected [5];
		logic [31:0] expStatus;
		logic [31:0] data;
		int          haltIndex;
		x         = 16'($urandom());
		y         = 16'($urandom());
		z         = 16'($urandom());
		haltIndex = 6;
		progWords.delete();
		progWords.push_back(encI(opOri, 5'd0, 5'd20, x));
		progWords.push_back(encI(opOri, 5'd0, 5'd21, y));
		progWords.push_back(encR(5'd20, 5'd21, 5'd22, funcAdd));
		progWords.push_back(encR(5'd20, 5'd21, 5'd23, funcSub));
		progWords.push_back(encI(opLui, 5'd0, 5'd24, z));
		progWords.push_back(encI(opOri, 5'd24, 5'd24, x));
		progWords.push_back(haltWord); // Slot haltIndex
		expected[0] = {16'h0000, x};
		expected[1] = {16'h0000, y};
		expected[2] = expected[0] + expected[1];
		expected[3] = expected[0] - expected[1];
		expected[4] = {z, x};
		expStatus   = {16'(haltIndex * 4), 14'd0, 1'b1, 1'b0}; // haltPc, halted, idle

		// Second pass is a plain restart of the same image
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 0) begin
				runProgram();
			end else begin
				startCore();
				hostRead(statusAddr, data);
				expectEqual("halt restart running", 32'd1, {30'd0, data[1:0]}); // Busy, not halted
				waitHalted();
			end
			hostRead(statusAddr, data);
			expectEqual($sformatf("halt status pass %0d", pass), expStatus, data);
			for (int k = 0; k < 5; k++) begin
				hostRead(regAt(20 + k), data);
				expectEqual($sformatf("halt pass %0d r%0d", pass, 20 + k), expected[k], data);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		apbIn     = '0;
		seedValue = $urandom(4); // Seed once
		@(negedge reset);
		testApbAccess();
		testArithmetic();
		testMemory();
		testControlFlow();
		testHaltStatus();
		if (checkFailures == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			reportFailure("Checks failed before the end of the run");
		end
	end

endmodule
